/* Makefile */
TOP := tb_stack_cpu

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

obj_dir/V$(TOP): files.f $(wildcard hdl/*.sv) $(wildcard bench/*.sv bench/*.svh)
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o V$(TOP)

sim: obj_dir/V$(TOP)
	@result=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$result"; \
	echo "$$result" | grep -q "^test passed$$"

clean:
	rm -rf obj_dir

/* bench/cpu_model.svh */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

logic [11:0] prog_img [32];
logic [7:0]  ram_val [256];
bit          ram_known [256];   // Set once a run has stored to the address.
logic [7:0]  exp_out [$];
bit          exp_fault;

// Interprets prog_img from address 0 with an empty stack and fills exp_out and exp_fault.
// Returns the address of an instruction whose result cannot be predicted (dup on an
// empty stack, or a load of a word never stored), else -1. Memory is kept on commit.
function automatic int run_model(input bit commit);
    logic [7:0] mem_v [256];
    bit         mem_k [256];
    logic [7:0] stk [$];
    logic [3:0] op;
    logic [7:0] arg;
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] r;
    int         pc;
    int         nxt;
    int         steps;
    bit         done;
    mem_v = ram_val;
    mem_k = ram_known;
    exp_out.delete();
    exp_fault = 1'b0;
    pc = 0;
    steps = 0;
    done = 1'b0;
    while (!done && steps < 64) begin
        op  = prog_img[pc][11:8];
        arg = prog_img[pc][7:0];
        nxt = (pc + 1) % 32;
        steps++;
        if (op == isa_pkg::halt) begin
            done = 1'b1;
        end else if ((op inside {isa_pkg::pushi, isa_pkg::load, isa_pkg::dup} && stk.size() >= 8)
                || (op inside {isa_pkg::store, isa_pkg::drop, isa_pkg::jz, isa_pkg::out}
                    && stk.size() < 1)
                || (op inside {isa_pkg::add, isa_pkg::sub, isa_pkg::and_op, isa_pkg::xor_op}
                    && stk.size() < 2)) begin
            exp_fault = 1'b1;   // Nothing of the faulting instruction takes effect.
            done = 1'b1;
        end else if ((op == isa_pkg::dup && stk.size() == 0)
                || (op == isa_pkg::load && !mem_k[arg])) begin
            return pc;
        end else begin
            case (op)
                isa_pkg::pushi: stk.push_back(arg);
                isa_pkg::load:  stk.push_back(mem_v[arg]);
                isa_pkg::store: begin
                    mem_v[arg] = stk.pop_back();
                    mem_k[arg] = 1'b1;
                end
                isa_pkg::add, isa_pkg::sub, isa_pkg::and_op, isa_pkg::xor_op: begin
                    b = stk.pop_back();   // Top of stack.
                    a = stk.pop_back();
                    case (op)
                        isa_pkg::add:    r = a + b;
                        isa_pkg::sub:    r = a - b;
                        isa_pkg::and_op: r = a & b;
                        default:         r = a ^ b;
                    endcase
                    stk.push_back(r);
                end
                isa_pkg::dup:  stk.push_back(stk[$]);
                isa_pkg::drop: void'(stk.pop_back());
                isa_pkg::jmp:  nxt = int'(arg[4:0]);
                isa_pkg::jz: begin
                    if (stk.pop_back() == 8'h00) begin
                        nxt = int'(arg[4:0]);
                    end
                end
                isa_pkg::out:  exp_out.push_back(stk.pop_back());
                default: ;
            endcase
            pc = nxt;
        end
    end
    if (commit) begin
        ram_val   = mem_v;
        ram_known = mem_k;
    end
    return -1;
endfunction

`endif

/* bench/tb_stack_cpu.sv */
`timescale 1ns/1ps

module tb_stack_cpu;

    localparam int n_progs     = 40;
    localparam int load_cycles = cpu_cfg_pkg::prog_depth + 2;
    localparam int run_cycles  = 3 * cpu_cfg_pkg::prog_depth + 20;
    localparam int cycle_limit = 8 + 16 + n_progs * (load_cycles + run_cycles);

    // Opcode for each 4-bit selector, one row per program kind:
    // arithmetic, memory, branch, underflow-prone and overflow-prone.
    localparam logic [63:0] op_table [5] = '{
        64'hED0C_CC97_6548_1111,
        64'h9CCC_8422_2333_1111,
        64'h758C_CCBB_BAA1_1111,
        64'h6CCC_4999_9811_1111,
        64'h9C11_8881_1111_1111
    };

    logic                  clk;
    logic                  rstn;
    cpu_cfg_pkg::prog_wr_t prog;
    logic                  start;
    cpu_cfg_pkg::out_t     out;
    cpu_cfg_pkg::status_t  status;
    logic [31:0]           lfsr_state;
    int                    cycles;

    `include "cpu_model.svh"

    stack_cpu i_dut (.clk, .rstn, .prog, .start, .out, .status);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1, stepped once per bit.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic void make_program(input int kind);
        int         n;
        int         d;
        logic [3:0] op;
        logic [7:0] arg;
        n = 8 + int'(rand_bits(5)) % 24;
        d = 0;   // Straight-line stack depth.
        for (int i = 0; i < cpu_cfg_pkg::prog_depth; i++) begin
            prog_img[i] = {isa_pkg::halt, 8'h00};
        end
        for (int i = 0; i < n; i++) begin
            op = op_table[kind][4'(rand_bits(4)) * 4 +: 4];
            if (kind < 3) begin
                if (op inside {isa_pkg::add, isa_pkg::sub, isa_pkg::and_op, isa_pkg::xor_op}
                        && d < 2) begin
                    op = isa_pkg::pushi;
                end
                if (op inside {isa_pkg::store, isa_pkg::drop, isa_pkg::jz, isa_pkg::out}
                        && d < 1) begin
                    op = isa_pkg::pushi;
                end
                if (op inside {isa_pkg::pushi, isa_pkg::load, isa_pkg::dup} && d >= 8) begin
                    op = isa_pkg::out;
                end
            end
            if (op inside {isa_pkg::pushi, isa_pkg::load, isa_pkg::dup}) begin
                d++;
            end else if (op inside {[4'd3:4'd7], isa_pkg::drop, isa_pkg::jz, isa_pkg::out}) begin
                d--;
            end
            arg = 8'(rand_bits(8));
            if (op inside {isa_pkg::load, isa_pkg::store}) begin
                arg = {3'(rand_bits(3)), 5'h15};   // Eight data words in use.
            end else if (op inside {isa_pkg::jmp, isa_pkg::jz}) begin
                arg = 8'(i + 1 + int'(rand_bits(5)) % (n - i));   // Forward, at most to halt.
            end else if (kind == 2 && op == isa_pkg::pushi && rand_bits(1) != 0) begin
                arg = 8'h00;   // Zero values give jz a branch to take.
            end
            prog_img[i] = {op, arg};
        end
    endfunction

    task automatic load_program();
        for (int a = 0; a < cpu_cfg_pkg::prog_depth; a++) begin
            @(negedge clk);
            prog.we    = 1'b1;
            prog.addr  = 5'(a);
            prog.instr = prog_img[a];
        end
        @(negedge clk);
        prog.we = 1'b0;
    endtask

    task automatic run_program(input int kind);
        int         bad;
        logic [7:0] want;
        make_program(kind);
        bad = run_model(1'b0);
        while (bad >= 0) begin
            prog_img[bad] = {isa_pkg::pushi, 8'(rand_bits(8))};
            bad = run_model(1'b0);
        end
        void'(run_model(1'b1));
        load_program();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        assert (status.busy && !status.halted && !status.fault)
            else fail_run("start did not begin a fresh run with halted and fault cleared");
        while (!status.halted) begin
            @(negedge clk);
            if (out.valid) begin
                assert (exp_out.size() > 0)
                    else fail_run("the processor emitted more values than expected");
                want = exp_out.pop_front();
                assert (out.data == want)
                    else fail_run($sformatf("ERR out.data = %h, expected %h", out.data, want));
            end
        end
        assert (exp_out.size() == 0)
            else fail_run("the processor halted before emitting all expected values");
        assert (status.fault == exp_fault)
            else fail_run($sformatf("ERR status.fault = %h, expected %h at the end of the run",
                                    status.fault, exp_fault));
        repeat (3) begin
            @(negedge clk);
            assert (!out.valid && status.halted && !status.busy)
                else fail_run("the processor kept running after it halted");
        end
    endtask

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            assert (cycles < cycle_limit)
                else fail_run("timeout, the processor did not finish the programs in time");
        end
    end

    initial begin
        lfsr_state = 32'hb114_f2e3;
        rstn  = 1'b0;
        start = 1'b0;
        prog  = '0;
        repeat (8) @(negedge clk);
        rstn = 1'b1;
        repeat (16) begin
            @(negedge clk);
            assert (!out.valid && status == '0)
                else fail_run("the processor became active after reset without a start");
        end
        for (int p = 0; p < n_progs; p++) begin
            run_program(p % 5);
        end
        $display("test passed");
        $finish;
    end

endmodule

/* files.f */
+incdir+bench
hdl/cpu_cfg_pkg.sv
hdl/isa_pkg.sv
hdl/sequencer.sv
hdl/program_counter.sv
hdl/program_store.sv
hdl/exec_unit.sv
hdl/data_ram.sv
hdl/operand_stack.sv
hdl/stack_cpu.sv
bench/tb_stack_cpu.sv

/* hdl/cpu_cfg_pkg.sv */
package cpu_cfg_pkg;

    localparam int word_w      = 8;
    localparam int prog_depth  = 32;
    localparam int pc_w        = 5;
    localparam int instr_w     = 12;   // 4-bit opcode plus 8-bit operand.
    localparam int ram_depth   = 256;
    localparam int ram_aw      = 8;
    localparam int stack_depth = 8;
    localparam int sp_w        = 3;    // Index into the stack array.
    localparam int depth_w     = 4;    // Counts 0 to 8.

    localparam logic [depth_w-1:0] depth_full = depth_w'(stack_depth);

    typedef struct packed {
        logic               we;
        logic [pc_w-1:0]    addr;
        logic [instr_w-1:0] instr;
    } prog_wr_t;

    typedef struct packed {
        logic              valid;
        logic [word_w-1:0] data;
    } out_t;

    typedef struct packed {
        logic busy;
        logic halted;
        logic fault;
    } status_t;

endpackage

/* hdl/data_ram.sv */
`timescale 1ns/1ps

module data_ram (
    input  logic                           clk,
    input  logic [cpu_cfg_pkg::ram_aw-1:0] addr,
    input  logic                           we,
    input  logic [cpu_cfg_pkg::word_w-1:0] wdata,
    output logic [cpu_cfg_pkg::word_w-1:0] rdata
);

    logic [cpu_cfg_pkg::word_w-1:0] mem [cpu_cfg_pkg::ram_depth];

    // Contents survive from one run to the next.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];   // Read every cycle.
    end

endmodule

/* hdl/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit (
    input  logic                            clk,
    input  logic                            rstn,
    input  isa_pkg::instr_t                 instr,
    input  logic                            retire_en,
    input  logic [cpu_cfg_pkg::word_w-1:0]  tos,
    input  logic [cpu_cfg_pkg::word_w-1:0]  nos,
    input  logic [cpu_cfg_pkg::depth_w-1:0] depth,
    input  logic [cpu_cfg_pkg::word_w-1:0]  rd_data,
    output isa_pkg::stack_op_t              stk_op,
    output logic [cpu_cfg_pkg::word_w-1:0]  stk_data,
    output logic [cpu_cfg_pkg::ram_aw-1:0]  ram_addr,
    output logic                            ram_we,
    output logic [cpu_cfg_pkg::word_w-1:0]  ram_wdata,
    output logic                            taken,
    output logic [cpu_cfg_pkg::pc_w-1:0]    target,
    output logic                            stop,
    output logic                            fault,
    output cpu_cfg_pkg::out_t               out
);

    isa_pkg::stack_op_t             kind;
    logic                           branch;
    logic                           commit;
    logic                           emit;
    logic                           out_valid;
    logic [cpu_cfg_pkg::word_w-1:0] out_data;

    always_comb begin
        kind     = isa_pkg::none;
        stk_data = tos;
        branch   = 1'b0;
        fault    = 1'b0;
        case (instr.op)
            isa_pkg::pushi, isa_pkg::load, isa_pkg::dup: begin
                kind  = isa_pkg::push;
                fault = (depth >= cpu_cfg_pkg::depth_full);   // Overflow.
                if (instr.op == isa_pkg::pushi) begin
                    stk_data = instr.operand;
                end else if (instr.op == isa_pkg::load) begin
                    stk_data = rd_data;
                end
            end
            isa_pkg::add, isa_pkg::sub, isa_pkg::and_op, isa_pkg::xor_op: begin
                kind  = isa_pkg::pop_replace;
                fault = (depth < cpu_cfg_pkg::depth_w'(2));
                case (instr.op)
                    isa_pkg::add:    stk_data = nos + tos;
                    isa_pkg::sub:    stk_data = nos - tos;
                    isa_pkg::and_op: stk_data = nos & tos;
                    default:         stk_data = nos ^ tos;
                endcase
            end
            isa_pkg::store, isa_pkg::drop, isa_pkg::jz, isa_pkg::out: begin
                kind   = isa_pkg::pop;
                fault  = (depth == '0);   // Underflow.
                branch = (instr.op == isa_pkg::jz) && (tos == '0);
            end
            isa_pkg::jmp: branch = 1'b1;
            default: ;
        endcase
    end

    // A faulting instruction retires without touching any state.
    assign commit = retire_en && !fault;
    assign emit   = commit && (instr.op == isa_pkg::out);

    assign stk_op    = commit ? kind : isa_pkg::none;
    assign ram_addr  = instr.operand;   // Read lands in rd_data by retire.
    assign ram_we    = commit && (instr.op == isa_pkg::store);
    assign ram_wdata = tos;
    assign taken     = commit && branch;
    assign target    = instr.operand[cpu_cfg_pkg::pc_w-1:0];
    assign stop      = (instr.op == isa_pkg::halt);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= emit;
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            out_data <= tos;
        end
    end

    assign out = cpu_cfg_pkg::out_t'{valid: out_valid, data: out_data};

endmodule

/* hdl/isa_pkg.sv */
package isa_pkg;

    localparam int opcode_w  = 4;
    localparam int operand_w = 8;

    // Codes 13 and 14 have no label and decode as nop.
    typedef enum logic [opcode_w-1:0] {
        nop    = 4'd0,
        pushi  = 4'd1,
        load   = 4'd2,
        store  = 4'd3,
        add    = 4'd4,
        sub    = 4'd5,
        and_op = 4'd6,
        xor_op = 4'd7,
        dup    = 4'd8,
        drop   = 4'd9,
        jmp    = 4'd10,
        jz     = 4'd11,
        out    = 4'd12,
        halt   = 4'd15
    } opcode_t;

    typedef struct packed {
        opcode_t              op;
        logic [operand_w-1:0] operand;
    } instr_t;

    // pop_replace removes the top and overwrites the entry below it.
    typedef enum logic [1:0] {
        none,
        push,
        pop,
        pop_replace
    } stack_op_t;

endpackage

/* hdl/operand_stack.sv */
`timescale 1ns/1ps

module operand_stack (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            clr,
    input  isa_pkg::stack_op_t              op,
    input  logic [cpu_cfg_pkg::word_w-1:0]  data,
    output logic [cpu_cfg_pkg::word_w-1:0]  tos,
    output logic [cpu_cfg_pkg::word_w-1:0]  nos,
    output logic [cpu_cfg_pkg::depth_w-1:0] depth
);

    logic [cpu_cfg_pkg::word_w-1:0] mem [cpu_cfg_pkg::stack_depth];
    logic [cpu_cfg_pkg::sp_w-1:0]   free_idx;
    logic [cpu_cfg_pkg::sp_w-1:0]   top_idx;
    logic [cpu_cfg_pkg::sp_w-1:0]   next_idx;

    // Top and next indices wrap around when the stack is shallow.
    assign free_idx = depth[cpu_cfg_pkg::sp_w-1:0];
    assign top_idx  = cpu_cfg_pkg::sp_w'(depth - 1'b1);
    assign next_idx = cpu_cfg_pkg::sp_w'(depth - 2'd2);

    assign tos = mem[top_idx];
    assign nos = mem[next_idx];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            depth <= '0;
        end else if (clr) begin
            depth <= '0;
        end else begin
            case (op)
                isa_pkg::push:                 depth <= depth + 1'b1;
                isa_pkg::pop, isa_pkg::pop_replace: depth <= depth - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (op == isa_pkg::push) begin
            mem[free_idx] <= data;
        end else if (op == isa_pkg::pop_replace) begin
            mem[next_idx] <= data;   // Result of a binary op takes the lower slot.
        end
    end

endmodule

/* hdl/program_counter.sv */
`timescale 1ns/1ps

module program_counter (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         clr,
    input  logic                         step,
    input  logic                         taken,
    input  logic [cpu_cfg_pkg::pc_w-1:0] target,
    output logic [cpu_cfg_pkg::pc_w-1:0] pc
);

    // Clear has priority; the counter wraps at the end of the program store.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc <= '0;
        end else if (clr) begin
            pc <= '0;
        end else if (step) begin
            if (taken) begin
                pc <= target;
            end else begin
                pc <= pc + 1'b1;
            end
        end
    end

endmodule

/* hdl/program_store.sv */
`timescale 1ns/1ps

module program_store (
    input  logic                         clk,
    input  cpu_cfg_pkg::prog_wr_t        prog,
    input  logic [cpu_cfg_pkg::pc_w-1:0] pc,
    input  logic                         fetch_en,
    output isa_pkg::instr_t              instr
);

    isa_pkg::instr_t mem [cpu_cfg_pkg::prog_depth];

    // The load port is only used while the processor is idle.
    always_ff @(posedge clk) begin
        if (prog.we) begin
            mem[prog.addr] <= isa_pkg::instr_t'(prog.instr);
        end
    end

    // Instruction register.
    // It holds its value through execute and retire, which is what
    // lets the execution unit decode it combinationally in both cycles.
    always_ff @(posedge clk) begin
        if (fetch_en) begin
            instr <= mem[pc];
        end
    end

endmodule

/* hdl/sequencer.sv */
`timescale 1ns/1ps

module sequencer (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 start,
    input  logic                 stop,
    input  logic                 fault,
    output logic                 fetch_en,
    output logic                 exec_en,
    output logic                 retire_en,
    output logic                 pc_clr,
    output cpu_cfg_pkg::status_t status
);

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_exec,
        st_retire,
        st_halt
    } state_t;

    state_t state;
    logic   fault_q;

    // A run may begin from idle or after a previous run has stopped.
    assign pc_clr    = ((state == st_idle) || (state == st_halt)) && start;
    assign fetch_en  = (state == st_fetch);
    assign exec_en   = (state == st_exec);
    assign retire_en = (state == st_retire);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= st_idle;
            fault_q <= 1'b0;
        end else begin
            case (state)
                st_idle, st_halt: begin
                    if (start) begin
                        state   <= st_fetch;
                        fault_q <= 1'b0;   // Flags of the last run go away.
                    end
                end
                st_fetch: state <= st_exec;
                st_exec:  state <= st_retire;
                st_retire: begin
                    if (stop || fault) begin
                        state   <= st_halt;
                        fault_q <= fault;
                    end else begin
                        state <= st_fetch;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign status = cpu_cfg_pkg::status_t'{
        busy:   fetch_en || exec_en || retire_en,
        halted: (state == st_halt),
        fault:  fault_q
    };

endmodule

/* hdl/stack_cpu.sv */
`timescale 1ns/1ps

module stack_cpu (
    input  logic                  clk,
    input  logic                  rstn,
    input  cpu_cfg_pkg::prog_wr_t prog,
    input  logic                  start,
    output cpu_cfg_pkg::out_t     out,
    output cpu_cfg_pkg::status_t  status
);

    logic                            fetch_en;
    logic                            retire_en;
    logic                            pc_clr;
    logic                            stop;
    logic                            fault;
    logic [cpu_cfg_pkg::pc_w-1:0]    pc;
    logic                            taken;
    logic [cpu_cfg_pkg::pc_w-1:0]    target;
    isa_pkg::instr_t                 instr;
    isa_pkg::stack_op_t              stk_op;
    logic [cpu_cfg_pkg::word_w-1:0]  stk_data;
    logic [cpu_cfg_pkg::word_w-1:0]  tos;
    logic [cpu_cfg_pkg::word_w-1:0]  nos;
    logic [cpu_cfg_pkg::depth_w-1:0] depth;
    logic [cpu_cfg_pkg::ram_aw-1:0]  ram_addr;
    logic                            ram_we;
    logic [cpu_cfg_pkg::word_w-1:0]  ram_wdata;
    logic [cpu_cfg_pkg::word_w-1:0]  rd_data;

    sequencer i_sequencer (
        .clk, .rstn, .start, .stop, .fault,
        .fetch_en, .exec_en(), .retire_en, .pc_clr, .status
    );

    program_counter i_pc (
        .clk, .rstn, .clr(pc_clr), .step(retire_en), .taken, .target, .pc
    );

    program_store i_prog (
        .clk, .prog, .pc, .fetch_en, .instr
    );

    exec_unit i_exec (
        .clk, .rstn, .instr, .retire_en, .tos, .nos, .depth, .rd_data,
        .stk_op, .stk_data, .ram_addr, .ram_we, .ram_wdata,
        .taken, .target, .stop, .fault, .out
    );

    data_ram i_ram (
        .clk, .addr(ram_addr), .we(ram_we), .wdata(ram_wdata), .rdata(rd_data)
    );

    // The stack is emptied at the start of every run.
    operand_stack i_stack (
        .clk, .rstn, .clr(pc_clr), .op(stk_op), .data(stk_data), .tos, .nos, .depth
    );

endmodule
